/* include/memsys_params.svh */
`ifndef MEMSYS_PARAMS_SVH
`define MEMSYS_PARAMS_SVH

// data word width
`define MEMSYS_WORD_W 16

// address map, DRAM below the I/O window
`define MEMSYS_DRAM_LAST 16'hF7FF
`define MEMSYS_IO_BASE 16'hF800
`define MEMSYS_IO_REGS 8

// cycles from an accepted DRAM request to its response
`define MEMSYS_DRAM_LAT 4

// requests the DRAM controller can hold at once
`define MEMSYS_CREDITS 2

`endif

/* hdl/memsys_pkg.sv */
`default_nettype none
`include "memsys_params.svh"

package memsys_pkg;

    typedef logic [`MEMSYS_WORD_W-1:0] word_t;
    typedef logic [15:0] addr_t;
    typedef logic [15:0] dram_addr_t;
    typedef logic [$clog2(`MEMSYS_IO_REGS)-1:0] io_idx_t;
    typedef logic [$clog2(`MEMSYS_CREDITS+1)-1:0] credit_t;

    // which half of an access a DRAM response belongs to
    typedef enum logic {
        TAG_INSTR,
        TAG_DATA
    } tag_t;

    typedef struct packed {
        logic       valid;
        logic       write;
        tag_t       tag;
        dram_addr_t addr;
        word_t      wdata;
    } dram_req_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t rdata;
    } dram_rsp_t;

    typedef struct packed {
        logic    valid;
        logic    write;
        io_idx_t idx;
        word_t   wdata;
    } io_req_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE_INSTR,
        ST_ISSUE_DATA,
        ST_WAIT
    } map_state_t;

endpackage

`default_nettype wire

/* hdl/io_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "memsys_params.svh"

module io_regs (
    input  logic                clk,
    input  logic                rst,
    input  memsys_pkg::io_req_t io_req,
    output memsys_pkg::word_t   io_rdata,
    output memsys_pkg::word_t   io_pins
);
    import memsys_pkg::*;

    word_t regs [`MEMSYS_IO_REGS];

    // reads answer one cycle later and hold until the next read
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `MEMSYS_IO_REGS; i++) begin
                regs[i] <= '0;
            end
            io_rdata <= '0;
        end else if (io_req.valid) begin
            if (io_req.write) begin
                regs[io_req.idx] <= io_req.wdata;
            end else begin
                io_rdata <= regs[io_req.idx];
            end
        end
    end

    // register 0 drives the pin bus
    assign io_pins = regs[0];

endmodule

`default_nettype wire

/* hdl/dram_ctl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "memsys_params.svh"

module dram_ctl (
    input  logic                  clk,
    input  logic                  rst,
    input  memsys_pkg::dram_req_t dram_req,
    output memsys_pkg::dram_rsp_t dram_rsp,
    output logic                  credit_ret
);
    import memsys_pkg::*;

    localparam int LAT = `MEMSYS_DRAM_LAT;

    word_t          mem [0:`MEMSYS_DRAM_LAST];
    logic [LAT-1:0] vld_pipe;
    tag_t           tag_pipe  [LAT];
    word_t          data_pipe [LAT];

    // array access happens at acceptance, the pipe only adds latency
    always_ff @(posedge clk) begin
        if (dram_req.valid) begin
            if (dram_req.write) begin
                mem[dram_req.addr] <= dram_req.wdata;
            end
            // old contents on a write, the mapper drops them
            data_pipe[0] <= mem[dram_req.addr];
            tag_pipe[0]  <= dram_req.tag;
        end
        for (int i = 1; i < LAT; i++) begin
            tag_pipe[i]  <= tag_pipe[i-1];
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[LAT-2:0], dram_req.valid};
        end
    end

    assign dram_rsp = '{
        valid: vld_pipe[LAT-1],
        tag:   tag_pipe[LAT-1],
        rdata: data_pipe[LAT-1]
    };

    // each response hands its credit back in the same cycle
    assign credit_ret = vld_pipe[LAT-1];

    a_inflight_limit: assert property (@(posedge clk) disable iff (!rst)
        $countones(vld_pipe) <= `MEMSYS_CREDITS)
        else $error("dram_ctl: more requests in flight than credits");

    // the mapper must never route an I/O or unmapped address here
    a_addr_in_range: assert property (@(posedge clk) disable iff (!rst)
        dram_req.valid |-> dram_req.addr <= dram_addr_t'(`MEMSYS_DRAM_LAST))
        else $error("dram_ctl: request outside the DRAM range");

endmodule

`default_nettype wire

/* hdl/mem_map.sv */
`timescale 1ns/1ps
`default_nettype none
`include "memsys_params.svh"

module mem_map (
    input  logic                  clk,
    input  logic                  rst,
    input  memsys_pkg::addr_t     pc,
    input  memsys_pkg::addr_t     data_addr,
    input  memsys_pkg::word_t     data_in,
    input  logic                  write_en,
    input  memsys_pkg::dram_rsp_t dram_rsp,
    input  logic                  credit_ret,
    input  memsys_pkg::word_t     io_rdata,
    output memsys_pkg::dram_req_t dram_req,
    output memsys_pkg::io_req_t   io_req,
    output memsys_pkg::word_t     instr,
    output memsys_pkg::word_t     read_data,
    output logic                  done
);
    import memsys_pkg::*;

    localparam addr_t   DRAM_LAST = `MEMSYS_DRAM_LAST;
    localparam addr_t   IO_FIRST  = `MEMSYS_IO_BASE;
    localparam addr_t   IO_LAST   = addr_t'(`MEMSYS_IO_BASE + `MEMSYS_IO_REGS - 1);
    localparam credit_t CREDITS   = credit_t'(`MEMSYS_CREDITS);

    map_state_t state;
    addr_t      last_pc;
    credit_t    credits;
    credit_t    outstanding;
    logic       io_pend;
    logic       wr_q;
    word_t      instr_buf;
    word_t      data_buf;
    word_t      instr_n;
    word_t      data_n;
    logic       instr_dram;
    logic       data_dram;
    logic       data_io;
    logic       acc_done;

    function automatic logic in_dram(addr_t a);
        return a <= DRAM_LAST;
    endfunction

    function automatic logic in_io(addr_t a);
        return (a >= IO_FIRST) && (a <= IO_LAST);
    endfunction

    // last_pc doubles as the fetch address while an access is running
    assign instr_dram = in_dram(last_pc);
    assign data_dram  = in_dram(data_addr);
    assign data_io    = in_io(data_addr);

    always_comb begin
        dram_req = '0;
        io_req   = '0;
        case (state)
            ST_ISSUE_INSTR: begin
                if (instr_dram && credits != '0) begin
                    dram_req.valid = 1'b1;
                    dram_req.tag   = TAG_INSTR;
                    dram_req.addr  = dram_addr_t'(last_pc);
                end
            end
            ST_ISSUE_DATA: begin
                if (data_dram) begin
                    if (credits != '0) begin
                        dram_req.valid = 1'b1;
                        dram_req.write = write_en;
                        dram_req.tag   = TAG_DATA;
                        dram_req.addr  = dram_addr_t'(data_addr);
                        dram_req.wdata = data_in;
                    end
                end else if (data_io) begin
                    io_req.valid = 1'b1;
                    io_req.write = write_en;
                    io_req.idx   = io_idx_t'(data_addr);
                    io_req.wdata = data_in;
                end
            end
            default: ;
        endcase
    end

    // results including whatever arrives this cycle
    always_comb begin
        instr_n = instr_buf;
        data_n  = data_buf;
        if (dram_rsp.valid && dram_rsp.tag == TAG_INSTR) begin
            instr_n = dram_rsp.rdata;
        end
        if (dram_rsp.valid && dram_rsp.tag == TAG_DATA) begin
            data_n = dram_rsp.rdata;
        end
        if (io_pend) begin
            data_n = io_rdata;
        end
    end

    // i/o reads land in the first wait cycle, so only DRAM responses can hold us up
    assign acc_done = (state == ST_WAIT) &&
                      (outstanding == '0 || (outstanding == credit_t'(1) && dram_rsp.valid));

    always_ff @(posedge clk) begin
        if (!rst) begin
            state       <= ST_IDLE;
            last_pc     <= 16'hFFFF;
            credits     <= CREDITS;
            outstanding <= '0;
            io_pend     <= 1'b0;
            done        <= 1'b0;
            instr       <= '0;
            read_data   <= '0;
        end else begin
            done    <= 1'b0;
            io_pend <= 1'b0;
            case ({dram_req.valid, credit_ret})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;
            endcase
            case ({dram_req.valid, dram_rsp.valid})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: ;
            endcase
            case (state)
                ST_IDLE: begin
                    if (pc != last_pc) begin
                        last_pc <= pc;
                        state   <= ST_ISSUE_INSTR;
                    end
                end
                ST_ISSUE_INSTR: begin
                    if (dram_req.valid || !instr_dram) begin
                        state <= ST_ISSUE_DATA;
                    end
                end
                ST_ISSUE_DATA: begin
                    if (dram_req.valid || !data_dram) begin
                        state <= ST_WAIT;
                    end
                    io_pend <= io_req.valid && !io_req.write;
                end
                ST_WAIT: begin
                    if (acc_done) begin
                        done  <= 1'b1;
                        instr <= instr_n;
                        if (!wr_q) begin
                            read_data <= data_n;
                        end
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        instr_buf <= instr_n;
        data_buf  <= data_n;
        // i/o fetches and unmapped reads come back as zero
        if (state == ST_ISSUE_INSTR && !instr_dram) begin
            instr_buf <= '0;
        end
        if (state == ST_ISSUE_DATA) begin
            wr_q <= write_en;
            if (!data_dram && !data_io) begin
                data_buf <= '0;
            end
        end
    end

    a_credit_range: assert property (@(posedge clk) disable iff (!rst)
        credits <= CREDITS)
        else $error("mem_map: credit count out of range");

    // a request may only go out while the controller still has room for it
    a_req_needs_credit: assert property (@(posedge clk) disable iff (!rst)
        dram_req.valid |-> outstanding < CREDITS)
        else $error("mem_map: DRAM request sent with no credit");

    // every credit is either held here or tied to a request in the controller
    a_credit_balance: assert property (@(posedge clk) disable iff (!rst)
        int'(credits) + int'(outstanding) == `MEMSYS_CREDITS)
        else $error("mem_map: credits and outstanding requests disagree");

endmodule

`default_nettype wire

/* hdl/memsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module memsys_top (
    input  logic              clk,
    input  logic              rst,
    input  memsys_pkg::addr_t pc,
    input  memsys_pkg::addr_t data_addr,
    input  memsys_pkg::word_t data_in,
    input  logic              write_en,
    output memsys_pkg::word_t instr,
    output memsys_pkg::word_t read_data,
    output logic              done,
    output memsys_pkg::word_t io_pins
);
    import memsys_pkg::*;

    dram_req_t dram_req;
    dram_rsp_t dram_rsp;
    logic      credit_ret;
    io_req_t   io_req;
    word_t     io_rdata;

    mem_map u_mem_map (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .data_addr  (data_addr),
        .data_in    (data_in),
        .write_en   (write_en),
        .dram_rsp   (dram_rsp),
        .credit_ret (credit_ret),
        .io_rdata   (io_rdata),
        .dram_req   (dram_req),
        .io_req     (io_req),
        .instr      (instr),
        .read_data  (read_data),
        .done       (done)
    );

    dram_ctl u_dram_ctl (
        .clk        (clk),
        .rst        (rst),
        .dram_req   (dram_req),
        .dram_rsp   (dram_rsp),
        .credit_ret (credit_ret)
    );

    io_regs u_io_regs (
        .clk      (clk),
        .rst      (rst),
        .io_req   (io_req),
        .io_rdata (io_rdata),
        .io_pins  (io_pins)
    );

endmodule

`default_nettype wire

/* dv/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst
);
    localparam int HALF_PERIOD = 10;
    localparam int RST_CYCLES  = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // active low, released just after an edge
    initial begin
        rst = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b1;
    end

endmodule

`default_nettype wire

/* dv/tb_memsys.sv */
`timescale 1ns/1ps
`default_nettype none
`include "memsys_params.svh"

module tb_memsys;
    import memsys_pkg::*;

    localparam int    LAT          = `MEMSYS_DRAM_LAT;
    // fill, write/read, fetch, i/o window and random traffic
    localparam int    NUM_ACCESSES = 64 + 16 + 4 + 22 + 40;
    localparam int    WAIT_LIMIT   = 4 * (LAT + 10);
    localparam addr_t IO_BASE      = `MEMSYS_IO_BASE;

    logic  clk;
    logic  rst;
    addr_t pc;
    addr_t data_addr;
    word_t data_in;
    logic  write_en;
    word_t instr;
    word_t read_data;
    logic  done;
    word_t io_pins;

    word_t dram_ref [64];
    word_t io_ref [`MEMSYS_IO_REGS];
    word_t exp_rd;
    int    errors;
    int    checks;

    clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    memsys_top u_memsys_top (
        .clk       (clk),
        .rst       (rst),
        .pc        (pc),
        .data_addr (data_addr),
        .data_in   (data_in),
        .write_en  (write_en),
        .instr     (instr),
        .read_data (read_data),
        .done      (done),
        .io_pins   (io_pins)
    );

    // every address bit reaches the fill word
    function automatic word_t fill_word(addr_t a);
        return a ^ {a[7:0], a[15:8]} ^ 16'h3C5A;
    endfunction

    function automatic logic is_io(addr_t a);
        return a[15:3] == IO_BASE[15:3];
    endfunction

    // i/o and unmapped fetches read as zero
    function automatic word_t ref_fetch(addr_t a);
        if (a <= `MEMSYS_DRAM_LAST) begin
            return dram_ref[a[5:0]];
        end
        return '0;
    endfunction

    function automatic word_t ref_read(addr_t a);
        if (a <= `MEMSYS_DRAM_LAST) begin
            return dram_ref[a[5:0]];
        end else if (is_io(a)) begin
            return io_ref[a[2:0]];
        end
        return '0;
    endfunction

    function automatic void ref_write(addr_t a, word_t d);
        if (a <= `MEMSYS_DRAM_LAST) begin
            dram_ref[a[5:0]] = d;
        end else if (is_io(a)) begin
            io_ref[a[2:0]] = d;
        end
    endfunction

    task automatic check_word(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pins(input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: io_pins is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic wait_done(output logic seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
            seen = (done === 1'b1);
        end
        if (!seen) begin
            errors++;
            $display("no done within %0d cycles after pc moved to %h", WAIT_LIMIT, pc);
        end
    endtask

    // one pc change, i.e. one fetch plus one data access
    task automatic access(input addr_t new_pc, input addr_t addr, input word_t wdata,
                          input logic wr);
        word_t exp_instr;
        logic  seen;
        exp_instr = ref_fetch(new_pc);
        if (!wr) begin
            exp_rd = ref_read(addr);
        end
        @(posedge clk);
        #1;
        pc        = new_pc;
        data_addr = addr;
        data_in   = wdata;
        write_en  = wr;
        wait_done(seen);
        if (seen) begin
            check_word("instr", instr, exp_instr);
            check_word("read_data", read_data, exp_rd);
        end
        if (wr) begin
            ref_write(addr, wdata);
        end
        check_pins(io_pins, io_ref[0]);
    endtask

    task automatic fill_dram();
        for (int i = 0; i < 64; i++) begin
            access(16'hFC00 + addr_t'(i), addr_t'(i), fill_word(addr_t'(i)), 1'b1);
        end
    endtask

    task automatic write_read_back();
        for (int i = 0; i < 8; i++) begin
            access(addr_t'(40 + i), addr_t'(3 * i + 1), word_t'(32'hA100 + i * 273), 1'b1);
        end
        for (int i = 0; i < 8; i++) begin
            access(addr_t'(48 + i), addr_t'(3 * i + 1), '0, 1'b0);
        end
    endtask

    task automatic fetch_with_data();
        access(16'd20, 16'd10, 16'hBEEF, 1'b1);
        access(16'd10, 16'd20, '0, 1'b0);
        access(16'd20, 16'd10, '0, 1'b0);
        // fetch goes out first, so it sees the word before this write
        access(16'd12, 16'd12, 16'h1234, 1'b1);
    endtask

    task automatic io_window();
        for (int i = 0; i < `MEMSYS_IO_REGS; i++) begin
            access(addr_t'(i), IO_BASE + addr_t'(i), word_t'(32'h5A00 + i * 17), 1'b1);
        end
        for (int i = 0; i < `MEMSYS_IO_REGS; i++) begin
            access(addr_t'(8 + i), IO_BASE + addr_t'(i), '0, 1'b0);
        end
        access(16'd16, 16'hF808, '0, 1'b0);
        access(16'd17, 16'hF80F, '0, 1'b0);
        access(16'd18, 16'hFFFF, '0, 1'b0);
        access(16'd19, 16'hF808, 16'hDEAD, 1'b1);
        access(16'd20, 16'hF808, '0, 1'b0);
        access(16'd21, IO_BASE, '0, 1'b0);
    endtask

    task automatic hold_pc();
        word_t held;
        // the last fetch was at the current pc
        held = ref_fetch(pc);
        repeat (20) begin
            @(posedge clk);
            #1;
            if (done !== 1'b0) begin
                errors++;
                $display("done pulsed at %0t although pc did not change", $time);
            end
            check_word("held instr", instr, held);
        end
    endtask

    task automatic random_traffic();
        addr_t p;
        addr_t a;
        for (int i = 0; i < 40; i++) begin
            case ($urandom % 3)
                0: a = addr_t'($urandom % 64);
                1: a = IO_BASE + addr_t'($urandom % 8);
                default: a = 16'hF808 + addr_t'($urandom % 8);
            endcase
            if ($urandom % 4 == 0) begin
                p = IO_BASE + addr_t'($urandom % 16);
            end else begin
                p = addr_t'($urandom % 64);
            end
            // stays in the same region and still counts as a change
            if (p == pc) begin
                p = p ^ 16'h0001;
            end
            access(p, a, word_t'($urandom), logic'($urandom % 2));
        end
    endtask

    initial begin
        repeat (NUM_ACCESSES * (LAT + 10) + 100) @(posedge clk);
        $display("timeout: the run did not finish within its cycle budget");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        pc        = 16'hFFFF;
        data_addr = '0;
        data_in   = '0;
        write_en  = 1'b0;
        errors    = 0;
        checks    = 0;
        exp_rd    = '0;
        void'($urandom(80));
        for (int i = 0; i < `MEMSYS_IO_REGS; i++) begin
            io_ref[i] = '0;
        end
        wait (rst === 1'b1);
        fill_dram();
        write_read_back();
        fetch_with_data();
        io_window();
        hold_pc();
        random_traffic();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
hdl/memsys_pkg.sv
hdl/io_regs.sv
hdl/dram_ctl.sv
hdl/mem_map.sv
hdl/memsys_top.sv
dv/clk_gen.sv
dv/tb_memsys.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_memsys
FILELIST   := list.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := NO ERRORS
VFLAGS     := --binary --timing -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
